// ==== design/dbg_pkg.sv ====
package dbg_pkg;

    // Sizes
    localparam int unsigned CPU_MAX   = 4;
    localparam int unsigned HARTSEL_W = 2;
    localparam int unsigned DATA_W    = 32;
    localparam int unsigned REG_NUM   = 16;
    localparam int unsigned REGNO_W   = 4;
    localparam int unsigned ADDR_W    = 4;

    // APB register map
    localparam logic [ADDR_W-1:0] ADDR_HARTCTL = 4'h0;
    localparam logic [ADDR_W-1:0] ADDR_STATUS  = 4'h4;
    localparam logic [ADDR_W-1:0] ADDR_COMMAND = 4'h8;
    localparam logic [ADDR_W-1:0] ADDR_DATA0   = 4'hC;

    // STATUS flag positions, halted bits sit in [CPU_MAX-1:0]
    localparam int unsigned STAT_BUSY = 30;
    localparam int unsigned STAT_ERR  = 31;

    // COMMAND cmdtype codes
    localparam logic [7:0] CMD_ACCESS = 8'd0;
    localparam logic [7:0] CMD_RUNCTL = 8'd1;

    typedef struct packed {
        logic [7:0]         cmdtype;
        logic [6:0]         rsvd_hi;
        logic               write;    // 1 = register write from DATA0
        logic [11:0]        rsvd_lo;
        logic [REGNO_W-1:0] regno;
    } cmd_access_t;

    typedef struct packed {
        logic [7:0]  cmdtype;
        logic [21:0] rsvd;
        logic        resume;
        logic        halt;
    } cmd_runctl_t;

    // One COMMAND word, two decodings selected by cmdtype
    typedef union packed {
        cmd_access_t access;
        cmd_runctl_t runctl;
    } dbg_cmd_u;

    typedef enum logic [1:0] {
        KIND_READ   = 2'd0,
        KIND_WRITE  = 2'd1,
        KIND_HALT   = 2'd2,
        KIND_RESUME = 2'd3
    } dport_kind_e;

    typedef struct packed {
        logic                 valid;
        logic [HARTSEL_W-1:0] hartsel;
        dport_kind_e          kind;
        logic [REGNO_W-1:0]   regno;
        logic [DATA_W-1:0]    wdata;
    } dport_req_t;

    typedef struct packed {
        logic              valid;
        logic              error;
        logic [DATA_W-1:0] rdata;
    } dport_resp_t;

    typedef struct packed {
        logic              psel;
        logic              penable;
        logic              pwrite;
        logic [ADDR_W-1:0] paddr;
        logic [DATA_W-1:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic              pready;
        logic [DATA_W-1:0] prdata;
        logic              pslverr;
    } apb_resp_t;

endpackage

// ==== design/dmi_apb_regs.sv ====
`timescale 1ns/1ps

module dmi_apb_regs (
    input  logic                        i_clk,
    input  logic                        i_rst_n,
    input  dbg_pkg::apb_req_t           i_apb,
    output dbg_pkg::apb_resp_t          o_apb,
    input  logic [dbg_pkg::DATA_W-1:0]  i_status,   // Packed STATUS word
    input  logic [dbg_pkg::DATA_W-1:0]  i_data0,
    input  logic                        i_busy,
    output logic                        o_data0_wr,
    output dbg_pkg::dport_req_t         o_req,
    output logic                        o_bad_cmd
);
    import dbg_pkg::*;

    logic [HARTSEL_W-1:0] hartctl;
    logic                 acc_wr;
    logic                 cmd_wr;
    logic                 cmd_busy;
    logic                 cmd_go;
    dbg_cmd_u             cmd;
    dport_req_t           req_d;
    logic                 bad_d;

    // Write in the access phase of a transfer
    assign acc_wr = i_apb.psel && i_apb.penable && i_apb.pwrite;
    assign cmd_wr = acc_wr && (i_apb.paddr == ADDR_COMMAND);

    // A request still on its way to the collector counts as busy too
    assign cmd_busy = i_busy || o_req.valid;
    assign cmd_go   = cmd_wr && !cmd_busy;

    assign o_data0_wr = acc_wr && (i_apb.paddr == ADDR_DATA0);
    assign cmd        = i_apb.pwdata;

    // Command decode
    always_comb begin
        req_d         = '0;
        bad_d         = 1'b0;
        req_d.hartsel = hartctl;
        req_d.wdata   = i_data0;    // Non-read kinds echo it back to DATA0
        case (cmd.access.cmdtype)
            CMD_ACCESS: begin
                req_d.valid = cmd_go;
                req_d.regno = cmd.access.regno;
                req_d.kind  = cmd.access.write ? KIND_WRITE : KIND_READ;
            end
            CMD_RUNCTL: begin
                req_d.valid = cmd_go;
                req_d.kind  = cmd.runctl.halt ? KIND_HALT : KIND_RESUME;
            end
            default: bad_d = cmd_go;    // Unknown cmdtype, no request
        endcase
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            hartctl   <= '0;
            o_req     <= '0;
            o_bad_cmd <= 1'b0;
        end else begin
            o_req     <= req_d;     // One-cycle pulse after the access phase
            o_bad_cmd <= bad_d;
            if (acc_wr && (i_apb.paddr == ADDR_HARTCTL)) begin
                hartctl <= i_apb.pwdata[HARTSEL_W-1:0];
            end
        end
    end

    // Read data, valid in the access cycle
    always_comb begin
        o_apb.pready  = 1'b1;
        o_apb.pslverr = cmd_wr && cmd_busy;
        case (i_apb.paddr)
            ADDR_HARTCTL: o_apb.prdata = {{(DATA_W-HARTSEL_W){1'b0}}, hartctl};
            ADDR_STATUS:  o_apb.prdata = i_status;
            ADDR_DATA0:   o_apb.prdata = i_data0;
            default:      o_apb.prdata = '0;    // COMMAND is write only
        endcase
    end

endmodule

// ==== design/dport_router.sv ====
`timescale 1ns/1ps

module dport_router #(
    parameter int unsigned cpu_num = 1
) (
    input  logic                         i_clk,
    input  logic                         i_rst_n,
    input  dbg_pkg::dport_req_t          i_req,
    output dbg_pkg::dport_req_t          o_hart_req [dbg_pkg::CPU_MAX],
    input  dbg_pkg::dport_resp_t         i_hart_resp [dbg_pkg::CPU_MAX],
    input  logic [dbg_pkg::CPU_MAX-1:0]  i_halted,
    output dbg_pkg::dport_resp_t         o_resp
);
    import dbg_pkg::*;

    logic                 in_range;
    logic                 is_runctl;
    logic                 req_ok;
    logic                 err_q;    // Pending error response
    logic [HARTSEL_W-1:0] sel_q;    // Hart that owns the response in flight
    dport_resp_t          hart_rsp;

    assign in_range  = (32'(i_req.hartsel) < cpu_num);
    assign is_runctl = (i_req.kind == KIND_HALT) || (i_req.kind == KIND_RESUME);

    // Register access needs a halted hart, halt and resume always go through
    assign req_ok = in_range && (is_runctl || i_halted[i_req.hartsel]);

    always_comb begin
        for (int i = 0; i < CPU_MAX; i++) begin
            o_hart_req[i]       = i_req;
            o_hart_req[i].valid = i_req.valid && req_ok
                                  && (i_req.hartsel == HARTSEL_W'(i));
        end
    end

    assign hart_rsp = i_hart_resp[sel_q];

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            err_q  <= 1'b0;
            sel_q  <= '0;
            o_resp <= '0;
        end else begin
            err_q <= i_req.valid && !req_ok;
            if (i_req.valid) begin
                sel_q <= i_req.hartsel;
            end
            // Error and hart responses leave on the same cycle
            o_resp.valid <= err_q || hart_rsp.valid;
            o_resp.error <= err_q;
            o_resp.rdata <= err_q ? '0 : hart_rsp.rdata;
        end
    end

endmodule

// ==== design/hart_dbg_target.sv ====
`timescale 1ns/1ps

module hart_dbg_target (
    input  logic                 i_clk,
    input  logic                 i_rst_n,
    input  dbg_pkg::dport_req_t  i_req,
    output dbg_pkg::dport_resp_t o_resp,
    output logic                 o_halted
);
    import dbg_pkg::*;

    logic [DATA_W-1:0] regs [REG_NUM];
    logic              halted;

    assign o_halted = halted;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            halted <= 1'b0;     // Harts come out of reset running
            o_resp <= '0;
            for (int r = 0; r < REG_NUM; r++) begin
                regs[r] <= '0;
            end
        end else begin
            o_resp.valid <= i_req.valid;
            o_resp.error <= 1'b0;   // Range and halt checks live in the router
            if (i_req.valid) begin
                // Default echo keeps DATA0 unchanged for non-read commands
                o_resp.rdata <= i_req.wdata;
                case (i_req.kind)
                    KIND_READ: begin
                        o_resp.rdata <= regs[i_req.regno];
                    end
                    KIND_WRITE: begin
                        regs[i_req.regno] <= i_req.wdata;
                    end
                    KIND_HALT: begin
                        halted <= 1'b1;
                    end
                    KIND_RESUME: begin
                        halted <= 1'b0;
                    end
                    default: ;
                endcase
            end
        end
    end

endmodule

// ==== design/dmi_resp_collect.sv ====
`timescale 1ns/1ps

module dmi_resp_collect (
    input  logic                        i_clk,
    input  logic                        i_rst_n,
    input  logic                        i_req_valid,    // Request pulse from decode
    input  logic                        i_bad_cmd,
    input  logic                        i_data0_wr,
    input  logic [dbg_pkg::DATA_W-1:0]  i_wdata,
    input  logic                        i_err_clr,
    input  dbg_pkg::dport_resp_t        i_resp,
    output logic                        o_busy,
    output logic                        o_error,
    output logic [dbg_pkg::DATA_W-1:0]  o_data0
);
    import dbg_pkg::*;

    // Busy spans request pulse to response
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_busy <= 1'b0;
        end else if (i_req_valid) begin
            o_busy <= 1'b1;
        end else if (i_resp.valid) begin
            o_busy <= 1'b0;
        end
    end

    // Sticky error, a new error wins over a clear in the same cycle
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_error <= 1'b0;
        end else if (i_bad_cmd || (i_resp.valid && i_resp.error)) begin
            o_error <= 1'b1;
        end else if (i_err_clr) begin
            o_error <= 1'b0;
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_data0 <= '0;
        end else if (i_resp.valid && !i_resp.error) begin
            o_data0 <= i_resp.rdata;
        end else if (i_data0_wr && !o_busy) begin
            o_data0 <= i_wdata;     // Debugger write, locked while a command runs
        end
    end

endmodule

// ==== design/debug_workgroup.sv ====
`timescale 1ns/1ps

module debug_workgroup #(
    parameter int unsigned cpu_num = 2
) (
    input  logic                i_clk,
    input  logic                i_rst_n,
    input  dbg_pkg::apb_req_t   i_apb,
    output dbg_pkg::apb_resp_t  o_apb
);
    import dbg_pkg::*;

    dport_req_t         dport_req;
    dport_resp_t        dport_resp;
    dport_req_t         hart_req [CPU_MAX];
    dport_resp_t        hart_resp [CPU_MAX];
    logic [CPU_MAX-1:0] halted;
    logic [DATA_W-1:0]  status;
    logic [DATA_W-1:0]  data0;
    logic               busy;
    logic               error;
    logic               data0_wr;
    logic               bad_cmd;
    logic               err_clr;

    // STATUS word
    always_comb begin
        status              = '0;
        status[CPU_MAX-1:0] = halted;
        status[STAT_BUSY]   = busy;
        status[STAT_ERR]    = error;
    end

    // Write 1 to the error bit clears it
    assign err_clr = i_apb.psel && i_apb.penable && i_apb.pwrite
                     && (i_apb.paddr == ADDR_STATUS) && i_apb.pwdata[STAT_ERR];

    dmi_apb_regs u_regs (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_apb      (i_apb),
        .o_apb      (o_apb),
        .i_status   (status),
        .i_data0    (data0),
        .i_busy     (busy),
        .o_data0_wr (data0_wr),
        .o_req      (dport_req),
        .o_bad_cmd  (bad_cmd)
    );

    dport_router #(
        .cpu_num(cpu_num)
    ) u_router (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_req       (dport_req),
        .o_hart_req  (hart_req),
        .i_hart_resp (hart_resp),
        .i_halted    (halted),
        .o_resp      (dport_resp)
    );

    dmi_resp_collect u_collect (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_req_valid (dport_req.valid),
        .i_bad_cmd   (bad_cmd),
        .i_data0_wr  (data0_wr),
        .i_wdata     (i_apb.pwdata),
        .i_err_clr   (err_clr),
        .i_resp      (dport_resp),
        .o_busy      (busy),
        .o_error     (error),
        .o_data0     (data0)
    );

    for (genvar i = 0; i < cpu_num; i++) begin : g_hart
        hart_dbg_target u_hart (
            .i_clk    (i_clk),
            .i_rst_n  (i_rst_n),
            .i_req    (hart_req[i]),
            .o_resp   (hart_resp[i]),
            .o_halted (halted[i])
        );
    end : g_hart

    // Empty slots never answer and read as running
    for (genvar i = cpu_num; i < CPU_MAX; i++) begin : g_idle
        assign hart_resp[i] = '0;
        assign halted[i]    = 1'b0;
    end : g_idle

endmodule

// ==== bench/debug_workgroup_checker.sv ====
`timescale 1ns/1ps

module debug_workgroup_checker (
    input logic                 i_clk,
    input logic                 i_rst_n,
    input dbg_pkg::apb_req_t    i_apb,
    input dbg_pkg::apb_resp_t   i_apb_rsp,
    input dbg_pkg::dport_req_t  i_req,
    input dbg_pkg::dport_resp_t i_resp,
    input logic                 i_busy
);
    import dbg_pkg::*;

    logic pending;              // Request sent, response still due
    logic bad_pready = 1'b0;
    logic bad_pulse  = 1'b0;
    logic bad_busy   = 1'b0;
    logic bad_resp   = 1'b0;
    logic fired;

    assign fired = bad_pready | bad_pulse | bad_busy | bad_resp;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            pending <= 1'b0;
        end else if (i_req.valid) begin
            pending <= 1'b1;
        end else if (i_resp.valid) begin
            pending <= 1'b0;
        end
    end

    a_pready: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (i_apb.psel && i_apb.penable) |-> i_apb_rsp.pready)
        else begin
            $error("pready low in an APB access phase");
            bad_pready = 1'b1;
        end

    a_pulse: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_req.valid |=> !i_req.valid)
        else begin
            $error("Request valid held longer than one cycle");
            bad_pulse = 1'b1;
        end

    a_busy: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_busy |-> !i_req.valid)
        else begin
            $error("New request issued while busy");
            bad_busy = 1'b1;
        end

    a_resp: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_resp.valid |-> pending)
        else begin
            $error("Response valid without an earlier request");
            bad_resp = 1'b1;
        end

endmodule

bind debug_workgroup debug_workgroup_checker u_chk (
    .i_clk     (i_clk),
    .i_rst_n   (i_rst_n),
    .i_apb     (i_apb),
    .i_apb_rsp (o_apb),
    .i_req     (dport_req),
    .i_resp    (dport_resp),
    .i_busy    (busy)
);

// ==== bench/tb_debug_workgroup.sv ====
`timescale 1ns/1ps

module tb_debug_workgroup;
    import dbg_pkg::*;

    localparam string       IN_FILE      = "bench/test_input.txt";
    localparam int unsigned CYC_PER_LINE = 40;
    localparam int unsigned POLL_MAX     = 16;  // STATUS reads before giving up on busy

    logic        clk;
    logic        rst_n;
    apb_req_t    apb_req;
    apb_resp_t   apb_rsp;
    string       lines[$];
    int unsigned wd_cycles = 0;

    debug_workgroup #(
        .cpu_num(2)
    ) uut (
        .i_clk   (clk),
        .i_rst_n (rst_n),
        .i_apb   (apb_req),
        .o_apb   (apb_rsp)
    );

    always #2 clk = ~clk;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TESTS FAILED");
        $fatal(1, "Simulation stopped");
    endtask

    task automatic check_word(input string name, input logic [DATA_W-1:0] exp,
                              input logic [DATA_W-1:0] act);
        if (act !== exp) begin
            abort_run($sformatf("error %s expected %08h actual %08h", name, exp, act));
        end
    endtask

    // Halted bits, busy and error compared one by one
    task automatic check_status(input string name, input logic [DATA_W-1:0] exp,
                                input logic [DATA_W-1:0] act);
        logic ok;
        ok = (act[CPU_MAX-1:0] === exp[CPU_MAX-1:0])
             && (act[STAT_BUSY] === exp[STAT_BUSY])
             && (act[STAT_ERR] === exp[STAT_ERR]);
        if (!ok) begin
            abort_run($sformatf("error %s expected STATUS %08h actual %08h", name, exp, act));
        end
    endtask

    task automatic check_err(input string name, input logic exp, input apb_resp_t rsp);
        if (rsp.pslverr !== exp) begin
            abort_run($sformatf("error %s expected pslverr %0b actual %0b",
                                name, exp, rsp.pslverr));
        end
    endtask

    task automatic idle_cycles(input int unsigned n);
        repeat (n) begin
            @(negedge clk);
            apb_req.psel    = 1'b0;
            apb_req.penable = 1'b0;
        end
    endtask

    // Setup and access phase with the response taken just before the access edge
    task automatic apb_xfer(input logic wr, input logic [ADDR_W-1:0] addr,
                            input logic [DATA_W-1:0] wdata, output apb_resp_t rsp);
        @(negedge clk);
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = wr;
        apb_req.paddr   = addr;
        apb_req.pwdata  = wdata;
        @(negedge clk);
        apb_req.penable = 1'b1;
        #1;
        rsp = apb_rsp;
        @(posedge clk);
    endtask

    task automatic poll_busy(input string name, output apb_resp_t rsp);
        int unsigned n;
        n = 0;
        do begin
            apb_xfer(1'b0, ADDR_STATUS, '0, rsp);
            n++;
        end while (rsp.prdata[STAT_BUSY] && (n < POLL_MAX));
        if (rsp.prdata[STAT_BUSY]) begin
            abort_run($sformatf("%s: busy never cleared after %0d STATUS reads", name, n));
        end
    endtask

    task automatic run_line(input string line);
        string             name;
        string             op;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] data;
        logic [DATA_W-1:0] exp;
        logic              exp_err;
        apb_resp_t         rsp;
        int                cnt;
        cnt = $sscanf(line, "%s %s %h %h %h %b", name, op, addr, data, exp, exp_err);
        if (cnt != 6) begin
            abort_run($sformatf("Stimulus line could not be parsed: %s", line));
        end
        case (op)
            "wr": begin
                idle_cycles($urandom % 4);
                apb_xfer(1'b1, addr, data, rsp);
            end
            "rd": begin
                idle_cycles($urandom % 4);
                apb_xfer(1'b0, addr, '0, rsp);
                check_word(name, exp, rsp.prdata);
            end
            "cmd": apb_xfer(1'b1, addr, data, rsp);    // No idle gap before it
            "poll": begin
                poll_busy(name, rsp);
                check_status(name, exp, rsp.prdata);
            end
            default: abort_run($sformatf("Unknown operation %s in test %s", op, name));
        endcase
        check_err(name, exp_err, rsp);
    endtask

    initial begin
        int    fd;
        string line;
        void'($urandom(54));
        clk     = 1'b0;
        rst_n   = 1'b0;
        apb_req = '0;
        fd = $fopen(IN_FILE, "r");
        if (fd == 0) begin
            abort_run("The stimulus file could not be opened");
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if ((line.len() > 1) && (line.getc(0) != "#")) begin
                lines.push_back(line);
            end
        end
        $fclose(fd);
        wd_cycles = lines.size() * CYC_PER_LINE + 20;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        foreach (lines[i]) begin
            run_line(lines[i]);
        end
        idle_cycles(2);
        if (uut.u_chk.fired) begin
            abort_run("The bound checker reported assertion failures");
        end else begin
            $display("TESTS PASSED");
        end
        $finish;
    end

    // Bound checker flags settle after the rising edge
    always @(negedge clk) begin
        if (uut.u_chk.fired) begin
            abort_run("The bound checker reported an assertion failure");
        end
    end

    // Watchdog sized from the number of test lines
    initial begin
        wait (wd_cycles != 0);
        repeat (wd_cycles) @(posedge clk);
        abort_run($sformatf("Watchdog expired, the run timed out after %0d cycles", wd_cycles));
    end

endmodule

// ==== bench/test_input.txt ====
# Columns: name op addr(hex) data(hex) expected(hex) pslverr
# wr/rd = APB write/read, cmd = COMMAND write with no idle gap, poll = wait for busy low, check STATUS
rst_status   rd   4 00000000 00000000 0
rst_data0    rd   c 00000000 00000000 0
halt0        cmd  8 01000001 00000000 0
halt0_st     poll 4 00000000 00000001 0
sel1         wr   0 00000001 00000000 0
sel1_rd      rd   0 00000000 00000001 0
halt1        cmd  8 01000001 00000000 0
halt1_st     poll 4 00000000 00000003 0
sel0         wr   0 00000000 00000000 0
resume0      cmd  8 01000002 00000000 0
resume0_st   poll 4 00000000 00000002 0
run_d0       wr   c 11111111 00000000 0
run_wr       cmd  8 00010005 00000000 0
run_wr_st    poll 4 00000000 80000002 0
run_d0_keep  rd   c 00000000 11111111 0
err_clr1     wr   4 80000000 00000000 0
err_clr1_st  rd   4 00000000 00000002 0
sel1b        wr   0 00000001 00000000 0
h1_d0        wr   c cafef00d 00000000 0
h1_wr5       cmd  8 00010005 00000000 0
h1_wr5_st    poll 4 00000000 00000002 0
h1_d0_clr    wr   c 00000000 00000000 0
h1_rd5       cmd  8 00000005 00000000 0
h1_rd5_st    poll 4 00000000 00000002 0
h1_rd5_val   rd   c 00000000 cafef00d 0
sel0b        wr   0 00000000 00000000 0
run_rd       cmd  8 00000005 00000000 0
run_rd_st    poll 4 00000000 80000002 0
halt0b       cmd  8 01000001 00000000 0
halt0b_st    poll 4 00000000 80000003 0
h0_rd5       cmd  8 00000005 00000000 0
h0_rd5_st    poll 4 00000000 80000003 0
h0_rd5_val   rd   c 00000000 00000000 0
err_clr2     wr   4 80000000 00000000 0
sel3         wr   0 00000003 00000000 0
oor_rd       cmd  8 00000005 00000000 0
oor_st       poll 4 00000000 80000003 0
err_clr3     wr   4 80000000 00000000 0
bad_type     cmd  8 05000000 00000000 0
bad_st       poll 4 00000000 80000003 0
err_clr4     wr   4 80000000 00000000 0
sel1c        wr   0 00000001 00000000 0
bb_d0        wr   c 5a5a5a5a 00000000 0
bb_wr7       cmd  8 00010007 00000000 0
bb_rej       cmd  8 01000002 00000000 1
bb_st        poll 4 00000000 00000003 0
bb_d0_clr    wr   c 00000000 00000000 0
bb_rd7       cmd  8 00000007 00000000 0
bb_rd7_st    poll 4 00000000 00000003 0
bb_val       rd   c 00000000 5a5a5a5a 0

// ==== tb.f ====
design/dbg_pkg.sv
design/dmi_apb_regs.sv
design/dport_router.sv
design/hart_dbg_target.sv
design/dmi_resp_collect.sv
design/debug_workgroup.sv
bench/debug_workgroup_checker.sv
bench/tb_debug_workgroup.sv

// ==== Makefile ====
# Verilator build and run for the debug workgroup testbench

VERILATOR ?= verilator
TOP       ?= tb_debug_workgroup
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
SIM_BIN   ?= $(OBJ_DIR)/V$(TOP)
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
SIM_ARGS  ?= +verilator+error+limit+100
SOURCES   := $(shell grep -v '^+' $(FILELIST))
STIMULUS  := bench/test_input.txt

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR) -o V$(TOP)

run: $(SIM_BIN) $(STIMULUS)
	@./$(SIM_BIN) $(SIM_ARGS) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "TESTS FAILED" $(LOG); then exit 1; fi; \
	if [ $$status -ne 0 ]; then echo "Simulator exited with status $$status"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
